/* all.f */
+incdir+tests
design/decodePkg.sv
design/instrQueue.sv
design/instrApbPort.sv
design/instrDecoder.sv
design/decodeUnit.sv
tests/decodeUnitTb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module decodeUnitTb -f all.f -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "decode unit run passed" \
    || { echo "decode unit run failed"; exit 1; }

/* tests/decodeRef.svh */
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

function automatic decodedT clearedBundle(input logic undefinedFlag);
    decodedT d;
    d = '0;
    d.undefinedInst = undefinedFlag;
    return d;
endfunction

// expected decode of one word, straight from the MIPS field layout
function automatic decodedT expectedBundle(input logic [instrWidth-1:0] w);
    decodedT    d;
    logic [5:0] opc;
    logic [5:0] fn;
    logic [4:0] rtField;
    opc        = w[31:26];
    fn         = w[5:0];
    rtField    = w[20:16];
    d          = '0;
    d.rs       = w[25:21];
    d.rt       = rtField;
    d.shamt    = w[10:6];
    d.jTarget  = w[25:0];
    d.regWaddr = w[15:11];
    d.immExt   = {{16{w[15]}}, w[15:0]};
    if (opc[5:2] == 4'b0011) begin
        d.immExt = {16'h0000, w[15:0]}; // andi ori xori lui
    end
    case (opc)
        6'h00: begin
            d.regWen = 1'b1;
            case (fn)
                6'h00: d.aluOp = aluSll;
                6'h02: d.aluOp = w[21] ? aluRotr : aluSrl;
                6'h03: d.aluOp = aluSra;
                6'h04: d.aluOp = aluSllv;
                6'h06: d.aluOp = w[6] ? aluRotrv : aluSrlv;
                6'h07: d.aluOp = aluSrav;
                6'h08: begin
                    d.regWen = 1'b0;
                    d.branch = brJReg;
                end
                6'h09: begin
                    d.branch  = brJReg;
                    d.linkPc8 = 1'b1;
                end
                6'h20: d.aluOp = aluAdd;
                6'h21: d.aluOp = aluAddu;
                6'h22: d.aluOp = aluSub;
                6'h23: d.aluOp = aluSubu;
                6'h24: d.aluOp = aluAnd;
                6'h25: d.aluOp = aluOr;
                6'h26: d.aluOp = aluXor;
                6'h27: d.aluOp = aluNor;
                6'h2a: d.aluOp = aluSlt;
                6'h2b: d.aluOp = aluSltu;
                default: return clearedBundle(1'b1);
            endcase
            d.aluSelA = (fn == 6'h00 || fn == 6'h02 || fn == 6'h03); // shamt shifts
        end
        6'h01: begin
            case (rtField)
                5'h00: d.branch = brBltz;
                5'h01: d.branch = brBgez;
                5'h10: d.branch = brBltz;
                5'h11: d.branch = brBgez;
                default: return clearedBundle(1'b0);
            endcase
            if (rtField[4]) begin // and-link forms
                d.linkPc8  = 1'b1;
                d.regWen   = 1'b1;
                d.regWaddr = linkReg;
            end
        end
        6'h02: d.branch = brJ;
        6'h03: begin
            d.branch   = brJ;
            d.linkPc8  = 1'b1;
            d.regWen   = 1'b1;
            d.regWaddr = linkReg;
        end
        6'h04: d.branch = brBeq;
        6'h05: d.branch = brBne;
        6'h06: d.branch = brBlez;
        6'h07: d.branch = brBgtz;
        6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
            d.regWen   = 1'b1;
            d.aluSelB  = 1'b1;
            d.regWaddr = rtField;
            case (opc[2:0])
                3'd0: d.aluOp = aluAdd;
                3'd1: d.aluOp = aluAddu;
                3'd2: d.aluOp = aluSlt;
                3'd3: d.aluOp = aluSltu;
                3'd4: d.aluOp = aluAnd;
                3'd5: d.aluOp = aluOr;
                3'd6: d.aluOp = aluXor;
                default: d.aluOp = aluLui;
            endcase
        end
        6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
            d.aluOp    = aluAddu; // base plus offset
            d.aluSelB  = 1'b1;
            d.memEn    = 1'b1;
            d.memRead  = 1'b1;
            d.memtoReg = 1'b1;
            d.regWen   = 1'b1;
            d.regWaddr = rtField;
        end
        6'h28, 6'h29, 6'h2b: begin
            d.aluOp    = aluAddu;
            d.aluSelB  = 1'b1;
            d.memEn    = 1'b1;
            d.memWrite = 1'b1;
        end
        default: return clearedBundle(1'b1);
    endcase
    return d;
endfunction

`endif

/* tests/decodeUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeUnitTb import decodePkg::*; ();

    localparam int clkPeriod = 40;
    localparam int waitLimit = 200; // cycles
    localparam logic [7:0] addrBad = 8'h10;

    logic    clk;
    logic    reset;
    apbReqT  apbReq;
    apbRspT  apbRsp;
    decodedT decoded;
    logic    outValid;
    logic    outReady;

    int valueErrors;
    int timeoutErrors;
    int readyMode; // 0 low, 1 high, 2 random

    decodedT               expQ[$];
    decodedT               frontBundle;
    logic                  frontValid;
    logic                  willPush;
    logic                  willPop;
    logic [instrWidth-1:0] pushSampled;
    logic                  stallExpected;
    logic                  badAddrExpected;
    logic [instrWidth-1:0] expStatus;

    `include "decodeRef.svh"

    decodeUnit u_decodeUnit (
        .clk      (clk),
        .reset    (reset),
        .apbReq   (apbReq),
        .apbRsp   (apbRsp),
        .decoded  (decoded),
        .outValid (outValid),
        .outReady (outReady)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        logic [31:0] r;
        #1;
        r = $urandom();
        case (readyMode)
            0: outReady = 1'b0;
            1: outReady = 1'b1;
            default: outReady = r[0] | r[1]; // ready about 3 of 4 cycles
        endcase
    end

    // sample handshakes mid cycle, apply them on the edge
    always @(negedge clk) begin
        willPush = apbReq.psel && apbReq.penable && apbReq.pwrite
                   && apbReq.paddr == addrPush && apbRsp.pready;
        pushSampled = apbReq.pwdata;
        willPop = outValid && outReady;
    end

    always @(posedge clk) begin
        if (reset) begin
            expQ.delete();
        end else begin
            if (willPop && expQ.size() > 0) begin
                void'(expQ.pop_front());
            end
            if (willPush) begin
                expQ.push_back(expectedBundle(pushSampled));
            end
        end
        frontValid  <= expQ.size() > 0;
        frontBundle <= (expQ.size() > 0) ? expQ[0] : '0;
    end

    bundleMatches: assert property (@(posedge clk) disable iff (reset)
        outValid && outReady |-> frontValid && decoded == frontBundle
    ) else begin
        valueErrors++;
        $display("** Error at %0t: bundle %h, expected %h (expected valid %b)",
                 $time, $sampled(decoded), $sampled(frontBundle), $sampled(frontValid));
    end

    stallHoldsReady: assert property (@(posedge clk) disable iff (reset)
        stallExpected && apbReq.psel && apbReq.penable |-> !apbRsp.pready
    ) else begin
        valueErrors++;
        $display("** Error at %0t: pready high while queue full", $time);
    end

    readsAtOnce: assert property (@(posedge clk) disable iff (reset)
        apbReq.psel && apbReq.penable && !apbReq.pwrite |-> apbRsp.pready
    ) else begin
        valueErrors++;
        $display("** Error at %0t: read did not complete in first access cycle", $time);
    end

    statusData: assert property (@(posedge clk) disable iff (reset)
        apbReq.psel && apbReq.penable && !apbReq.pwrite && apbReq.paddr == addrStatus
        |-> apbRsp.prdata == expStatus
    ) else begin
        valueErrors++;
        $display("** Error at %0t: status %0d, expected %0d",
                 $time, $sampled(apbRsp.prdata), $sampled(expStatus));
    end

    badAddrError: assert property (@(posedge clk) disable iff (reset)
        badAddrExpected && apbReq.psel && apbReq.penable && apbRsp.pready |-> apbRsp.pslverr
    ) else begin
        valueErrors++;
        $display("** Error at %0t: unknown address without pslverr", $time);
    end

    knownAddrOk: assert property (@(posedge clk) disable iff (reset)
        apbReq.psel && apbReq.penable && apbRsp.pready
        && (apbReq.paddr == addrPush || apbReq.paddr == addrStatus) |-> !apbRsp.pslverr
    ) else begin
        valueErrors++;
        $display("** Error at %0t: pslverr on a valid address", $time);
    end

    task automatic apbTransfer(input logic write, input logic [7:0] addr,
                               input logic [instrWidth-1:0] data, output int waits);
        @(posedge clk);
        #1;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = data;
        @(posedge clk);
        #1;
        apbReq.penable = 1'b1;
        waits = 0;
        @(negedge clk);
        while (!apbRsp.pready && waits < waitLimit) begin
            waits++;
            @(negedge clk);
        end
        if (!apbRsp.pready) begin
            timeoutErrors++;
            $display("APB transfer to address %h never completed", addr);
        end
        @(posedge clk);
        #1;
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    task automatic pushWord(input logic [instrWidth-1:0] w);
        int waits;
        apbTransfer(1'b1, addrPush, w, waits);
    endtask

    task automatic statusRead(input logic [instrWidth-1:0] expected);
        int waits;
        expStatus = expected;
        apbTransfer(1'b0, addrStatus, '0, waits);
    endtask

    task automatic waitDrained();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((expQ.size() > 0 || outValid) && cycles < waitLimit) begin
            cycles++;
            @(negedge clk);
        end
        if (expQ.size() > 0 || outValid) begin
            timeoutErrors++;
            $display("decoder did not drain, %0d bundles still expected", expQ.size());
        end
    endtask

    initial begin
        #2_000_000;
        $display("simulation stopped by the watchdog at %0t", $time);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [5:0]            keptFuncts [16];
        logic [5:0]            memImmOps [16];
        logic [4:0]            regimmRts [4];
        logic [instrWidth-1:0] droppedWords [12];
        logic [31:0]           r;
        logic [instrWidth-1:0] w;
        int                    waits;
        void'($urandom(39957));
        keptFuncts = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h20, 6'h21,
                       6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
        memImmOps = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
                      6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b};
        regimmRts = '{5'h00, 5'h01, 5'h10, 5'h11};
        droppedWords = '{
            32'h0043_0018,  // mult
            32'h0000_000c,  // syscall
            32'h0000_000d,  // break
            32'h0043_0034,  // teq
            32'h4200_0018,  // eret
            32'h4080_6000,  // mtc0
            32'h7043_0002,  // special2 mul
            32'h0043_100a,  // movz
            32'h0000_000f,  // sync
            32'h0408_0000,  // tgei, regimm
            32'h07ff_0000,  // synci, regimm
            32'hfc00_0000   // unused opcode
        };
        clk             = 1'b0;
        reset           = 1'b1;
        apbReq          = '0;
        outReady        = 1'b0;
        readyMode       = 0;
        valueErrors     = 0;
        timeoutErrors   = 0;
        willPush        = 1'b0;
        willPop         = 1'b0;
        pushSampled     = '0;
        stallExpected   = 1'b0;
        badAddrExpected = 1'b0;
        expStatus       = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // register ALU ops, rotate bits off then on
        readyMode = 2;
        for (int i = 0; i < 16; i++) begin
            for (int rot = 0; rot < 2; rot++) begin
                r = $urandom();
                w = {6'h00, r[25:6], keptFuncts[i]};
                w[21] = rot[0];
                w[6] = rot[0];
                pushWord(w);
            end
        end
        waitDrained();

        // immediates, loads, stores with both immediate signs
        for (int i = 0; i < 16; i++) begin
            for (int s = 0; s < 2; s++) begin
                r = $urandom();
                w = {memImmOps[i], r[25:0]};
                w[15] = s[0];
                pushWord(w);
            end
        end
        waitDrained();

        for (int op = 2; op < 8; op++) begin // j jal beq bne blez bgtz
            r = $urandom();
            pushWord({op[5:0], r[25:0]});
        end
        for (int i = 0; i < 4; i++) begin
            r = $urandom();
            pushWord({6'h01, r[25:21], regimmRts[i], r[15:0]});
        end
        r = $urandom();
        pushWord({6'h00, r[25:6], 6'h08}); // jr
        r = $urandom();
        pushWord({6'h00, r[25:6], 6'h09}); // jalr
        waitDrained();

        for (int i = 0; i < 12; i++) begin
            pushWord(droppedWords[i]);
        end
        waitDrained();

        // back-pressure with the consumer stalled
        readyMode = 0;
        @(posedge clk);
        for (int n = 0; n < queueDepth + 1; n++) begin
            r = $urandom();
            pushWord({memImmOps[n], r[25:0]});
        end
        statusRead(instrWidth'(queueDepth));
        fork
            begin
                stallExpected = 1'b1;
                r = $urandom();
                apbTransfer(1'b1, addrPush, {6'h09, r[25:0]}, waits);
            end
            begin
                repeat (6) @(posedge clk);
                stallExpected = 1'b0;
                readyMode = 1;
            end
        join
        stalledPush: assert (waits >= 4) else begin
            valueErrors++;
            $display("** Error at %0t: push waited %0d cycles while full", $time, waits);
        end
        waitDrained();
        statusRead('0);

        badAddrExpected = 1'b1;
        apbTransfer(1'b1, addrBad, $urandom(), waits);
        apbTransfer(1'b0, addrBad, '0, waits);
        badAddrExpected = 1'b0;
        waitDrained();
        repeat (4) @(posedge clk); // a stray bundle would show up here

        $display("checks done: %0d value errors, %0d timeouts", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/decodeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeUnit import decodePkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  apbReqT  apbReq,
    output apbRspT  apbRsp,
    output decodedT decoded,
    output logic    outValid,
    input  logic    outReady
);

    logic                  pushValid;
    logic [instrWidth-1:0] pushWord;
    logic                  queueFull;
    logic                  queueEmpty;
    logic [countWidth-1:0] queueCount;
    logic                  popValid;
    logic [instrWidth-1:0] headWord;

    instrApbPort u_port (
        .clk        (clk),
        .reset      (reset),
        .apbReq     (apbReq),
        .apbRsp     (apbRsp),
        .pushValid  (pushValid),
        .pushWord   (pushWord),
        .queueFull  (queueFull),
        .queueCount (queueCount)
    );

    instrQueue u_queue (
        .clk       (clk),
        .reset     (reset),
        .pushValid (pushValid),
        .pushWord  (pushWord),
        .popValid  (popValid),
        .headWord  (headWord),
        .empty     (queueEmpty),
        .full      (queueFull),
        .count     (queueCount)
    );

    instrDecoder u_decoder (
        .clk      (clk),
        .reset    (reset),
        .headWord (headWord),
        .empty    (queueEmpty),
        .popValid (popValid),
        .decoded  (decoded),
        .outValid (outValid),
        .outReady (outReady)
    );

endmodule

`default_nettype wire

/* design/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import decodePkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [instrWidth-1:0] headWord,
    input  logic                  empty,
    output logic                  popValid,
    output decodedT               decoded,
    output logic                  outValid,
    input  logic                  outReady
);

    opcodeT                  op;
    functT                   funct;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [4:0]              shamt;
    logic [instrWidth-1:0]   immExt;

    aluOpT                   aluOp;
    logic                    aluSelA;
    logic                    aluSelB;
    logic                    regWen;
    logic                    memEn;
    logic                    memRead;
    logic                    memWrite;
    logic                    memtoReg;
    logic                    undefinedInst;
    logic                    regimmKnown;
    branchT                  branchKind;
    logic                    linkPc8;
    logic [regAddrWidth-1:0] regWaddr;
    decodedT                 nextBundle;

    assign op    = opcodeT'(headWord[31:26]);
    assign funct = functT'(headWord[5:0]);
    assign rs    = headWord[25:21];
    assign rt    = headWord[20:16];
    assign rd    = headWord[15:11];
    assign shamt = headWord[10:6];

    // logic immediates zero extend
    assign immExt = (op inside {opAndi, opOri, opXori, opLui}) ?
                    {16'b0, headWord[15:0]} : {{16{headWord[15]}}, headWord[15:0]};

    always_comb begin : controlDecode
        aluOp         = aluNop;
        aluSelA       = 1'b0;
        aluSelB       = 1'b0;
        regWen        = 1'b0;
        memEn         = 1'b0;
        memRead       = 1'b0;
        memWrite      = 1'b0;
        memtoReg      = 1'b0;
        undefinedInst = 1'b0;
        regimmKnown   = 1'b1;
        case (op)
            opSpecial: begin
                regWen = 1'b1;
                case (funct)
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnXor:  aluOp = aluXor;
                    fnNor:  aluOp = aluNor;
                    fnSlt:  aluOp = aluSlt;
                    fnSltu: aluOp = aluSltu;
                    fnAdd:  aluOp = aluAdd;
                    fnAddu: aluOp = aluAddu;
                    fnSub:  aluOp = aluSub;
                    fnSubu: aluOp = aluSubu;
                    fnSllv: aluOp = aluSllv;
                    fnSrav: aluOp = aluSrav;
                    fnSrlv: aluOp = headWord[6] ? aluRotrv : aluSrlv;
                    fnSll: begin
                        aluOp   = aluSll;
                        aluSelA = 1'b1;
                    end
                    fnSrl: begin
                        aluOp   = headWord[21] ? aluRotr : aluSrl;
                        aluSelA = 1'b1;
                    end
                    fnSra: begin
                        aluOp   = aluSra;
                        aluSelA = 1'b1;
                    end
                    fnJr:   regWen = 1'b0;
                    fnJalr: aluOp = aluNop; // rd gets pc+8
                    default: begin
                        regWen        = 1'b0;
                        undefinedInst = 1'b1;
                    end
                endcase
            end
            opLb, opLbu, opLh, opLhu, opLw: begin
                aluOp    = aluAddu; // address = rs + imm
                aluSelB  = 1'b1;
                memEn    = 1'b1;
                memRead  = 1'b1;
                memtoReg = 1'b1;
                regWen   = 1'b1;
            end
            opSb, opSh, opSw: begin
                aluOp    = aluAddu;
                aluSelB  = 1'b1;
                memEn    = 1'b1;
                memWrite = 1'b1;
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                regWen  = 1'b1;
                aluSelB = 1'b1;
                case (op)
                    opAddi:  aluOp = aluAdd;
                    opAddiu: aluOp = aluAddu;
                    opSlti:  aluOp = aluSlt;
                    opSltiu: aluOp = aluSltu;
                    opAndi:  aluOp = aluAnd;
                    opOri:   aluOp = aluOr;
                    opXori:  aluOp = aluXor;
                    default: aluOp = aluLui;
                endcase
            end
            opJal: regWen = 1'b1;
            opJ, opBeq, opBne, opBgtz, opBlez: aluOp = aluNop;
            opRegimm: begin
                case (regimmT'(rt))
                    rtBgezal, rtBltzal: regWen = 1'b1;
                    rtBgez, rtBltz:     regWen = 1'b0;
                    default:            regimmKnown = 1'b0;
                endcase
            end
            default: undefinedInst = 1'b1;
        endcase
    end

    always_comb begin : branchDecode
        branchKind = brNone;
        linkPc8    = 1'b0;
        case (op)
            opSpecial: begin
                if (funct inside {fnJr, fnJalr}) begin
                    branchKind = brJReg;
                    linkPc8    = (funct == fnJalr);
                end
            end
            opJ:    branchKind = brJ;
            opJal: begin
                branchKind = brJ;
                linkPc8    = 1'b1;
            end
            opBeq:  branchKind = brBeq;
            opBne:  branchKind = brBne;
            opBgtz: branchKind = brBgtz;
            opBlez: branchKind = brBlez;
            opRegimm: begin
                case (regimmT'(rt))
                    rtBgez:   branchKind = brBgez;
                    rtBltz:   branchKind = brBltz;
                    rtBgezal: {branchKind, linkPc8} = {brBgez, 1'b1};
                    rtBltzal: {branchKind, linkPc8} = {brBltz, 1'b1};
                    default:  branchKind = brNone;
                endcase
            end
            default: branchKind = brNone;
        endcase
    end

    always_comb begin : waddrSelect
        regWaddr = rd;
        case (op)
            opLb, opLbu, opLh, opLhu, opLw,
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: regWaddr = rt;
            opJal: regWaddr = linkReg;
            opRegimm: begin
                if (regimmT'(rt) inside {rtBgezal, rtBltzal}) begin
                    regWaddr = linkReg;
                end
            end
            default: regWaddr = rd;
        endcase
    end

    always_comb begin : bundleAssemble
        nextBundle.aluOp         = aluOp;
        nextBundle.aluSelA       = aluSelA;
        nextBundle.aluSelB       = aluSelB;
        nextBundle.regWen        = regWen;
        nextBundle.regWaddr      = regWaddr;
        nextBundle.memEn         = memEn;
        nextBundle.memRead       = memRead;
        nextBundle.memWrite      = memWrite;
        nextBundle.memtoReg      = memtoReg;
        nextBundle.branch        = branchKind;
        nextBundle.linkPc8       = linkPc8;
        nextBundle.rs            = rs;
        nextBundle.rt            = rt;
        nextBundle.shamt         = shamt;
        nextBundle.immExt        = immExt;
        nextBundle.jTarget       = headWord[25:0];
        nextBundle.undefinedInst = 1'b0;
        // unknown codes leave nothing but the flag
        if (undefinedInst || !regimmKnown) begin
            nextBundle               = '0;
            nextBundle.undefinedInst = undefinedInst;
        end
    end

    // take a word when the output slot is free or draining this cycle
    assign popValid = !empty && (!outValid || outReady);

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (popValid) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (popValid) begin
            decoded <= nextBundle;
        end
    end

    bundleHeldWhileStalled: assert property (
        @(posedge clk) disable iff (reset)
        outValid && !outReady |=> outValid && $stable(decoded)
    ) else $error("decoded bundle changed under back-pressure");

endmodule

`default_nettype wire

/* design/instrApbPort.sv */
`timescale 1ns/1ps
`default_nettype none

module instrApbPort import decodePkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  apbReqT                apbReq,
    output apbRspT                apbRsp,
    output logic                  pushValid,
    output logic [instrWidth-1:0] pushWord,
    input  logic                  queueFull,
    input  logic [countWidth-1:0] queueCount
);

    logic accessPhase;
    logic hitPush;
    logic hitStatus;
    logic writePush;

    assign accessPhase = apbReq.psel && apbReq.penable;
    assign hitPush     = (apbReq.paddr == addrPush);
    assign hitStatus   = (apbReq.paddr == addrStatus);
    assign writePush   = accessPhase && apbReq.pwrite && hitPush;

    // word goes in on the edge that completes the transfer
    assign pushValid = writePush && !queueFull;
    assign pushWord  = apbReq.pwdata;

    always_comb begin
        apbRsp = '0;
        if (accessPhase) begin
            apbRsp.pready  = !writePush || !queueFull; // wait states while full
            apbRsp.pslverr = !hitPush && !hitStatus;
            if (!apbReq.pwrite && hitStatus) begin
                apbRsp.prdata = instrWidth'(queueCount);
            end
        end
    end

    // a read of the push address returns zero, a write to status is dropped

    readyOnlyInAccess: assert property (
        @(posedge clk) disable iff (reset)
        apbRsp.pready |-> accessPhase
    ) else $error("pready outside access phase");

    // host must hold a stalled transfer until it completes
    stalledTransferHeld: assert property (
        @(posedge clk) disable iff (reset)
        accessPhase && !apbRsp.pready |=>
            accessPhase && $stable(apbReq.paddr) && $stable(apbReq.pwrite)
            && $stable(apbReq.pwdata)
    ) else $error("stalled APB transfer changed");

    setupThenAccess: assert property (
        @(posedge clk) disable iff (reset)
        apbReq.psel && !apbReq.penable |=> apbReq.psel && apbReq.penable
    ) else $error("setup cycle not followed by access");

endmodule

`default_nettype wire

/* design/instrQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module instrQueue import decodePkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pushValid,
    input  logic [instrWidth-1:0] pushWord,
    input  logic                  popValid,
    output logic [instrWidth-1:0] headWord,
    output logic                  empty,
    output logic                  full,
    output logic [countWidth-1:0] count
);

    logic [instrWidth-1:0] mem [queueDepth];
    logic [ptrWidth-1:0]   wrPtr;
    logic [ptrWidth-1:0]   rdPtr;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(queueDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign headWord = mem[rdPtr];
    assign empty    = (count == '0);
    assign full     = (count == countWidth'(queueDepth));

    always_ff @(posedge clk) begin
        if (pushValid) begin
            mem[wrPtr] <= pushWord;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (popValid) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({pushValid, popValid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or push and pop together
            endcase
        end
    end

    noPushWhenFull: assert property (
        @(posedge clk) disable iff (reset)
        pushValid |-> !full
    ) else $error("push into full queue");

    noPopWhenEmpty: assert property (
        @(posedge clk) disable iff (reset)
        popValid |-> !empty
    ) else $error("pop from empty queue");

endmodule

`default_nettype wire

/* design/decodePkg.sv */
`default_nettype none

package decodePkg;

    localparam int instrWidth   = 32;
    localparam int regAddrWidth = 5;
    localparam int queueDepth   = 4;
    localparam int countWidth   = $clog2(queueDepth + 1); // holds 0..queueDepth
    localparam int ptrWidth     = $clog2(queueDepth);

    localparam logic [7:0] addrPush   = 8'h00;
    localparam logic [7:0] addrStatus = 8'h04;

    localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

    // major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opRegimm  = 6'b000001,
        opJ       = 6'b000010,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opBlez    = 6'b000110,
        opBgtz    = 6'b000111,
        opAddi    = 6'b001000,
        opAddiu   = 6'b001001,
        opSlti    = 6'b001010,
        opSltiu   = 6'b001011,
        opAndi    = 6'b001100,
        opOri     = 6'b001101,
        opXori    = 6'b001110,
        opLui     = 6'b001111,
        opLb      = 6'b100000,
        opLh      = 6'b100001,
        opLw      = 6'b100011,
        opLbu     = 6'b100100,
        opLhu     = 6'b100101,
        opSb      = 6'b101000,
        opSh      = 6'b101001,
        opSw      = 6'b101011
    } opcodeT;

    // special group, instr[5:0]; rotr is srl with instr[21] set, rotrv is srlv with instr[6] set
    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnSra  = 6'b000011,
        fnSllv = 6'b000100,
        fnSrlv = 6'b000110,
        fnSrav = 6'b000111,
        fnJr   = 6'b001000,
        fnJalr = 6'b001001,
        fnAdd  = 6'b100000,
        fnAddu = 6'b100001,
        fnSub  = 6'b100010,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnNor  = 6'b100111,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } functT;

    typedef enum logic [4:0] {
        rtBltz   = 5'b00000,
        rtBgez   = 5'b00001,
        rtBltzal = 5'b10000,
        rtBgezal = 5'b10001
    } regimmT;

    typedef enum logic [7:0] {
        aluNop, aluAnd, aluOr, aluXor, aluNor, aluSlt, aluSltu,
        aluAdd, aluAddu, aluSub, aluSubu,
        aluSll, aluSllv, aluSrl, aluSrlv, aluSra, aluSrav, aluRotr, aluRotrv,
        aluLui
    } aluOpT;

    typedef enum logic [3:0] {
        brNone, brJReg, brJ, brBeq, brBne, brBgtz, brBlez, brBgez, brBltz
    } branchT;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [7:0]            paddr;
        logic [instrWidth-1:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic                  pready;
        logic [instrWidth-1:0] prdata;
        logic                  pslverr;
    } apbRspT;

    typedef struct packed {
        aluOpT                   aluOp;
        logic                    aluSelA;  // shamt as operand a
        logic                    aluSelB;  // immExt as operand b
        logic                    regWen;
        logic [regAddrWidth-1:0] regWaddr;
        logic                    memEn;
        logic                    memRead;
        logic                    memWrite;
        logic                    memtoReg;
        branchT                  branch;
        logic                    linkPc8;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [4:0]              shamt;
        logic [instrWidth-1:0]   immExt;
        logic [25:0]             jTarget;
        logic                    undefinedInst;
    } decodedT;

endpackage

`default_nettype wire
